//--- Bender.yml
package:
  name: apu_sound

sources:
  - apu_reg_pkg.sv
  - apu_sound_pkg.sv
  - apu_decode.sv
  - apu_regs.sv
  - apu_frame_seq.sv
  - apu_square.sv
  - apu_mixer.sv
  - apu_top.sv
  - target: simulation
    files:
      - tb_apu_top.sv

//--- apu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module apu_decode import apu_reg_pkg::*; (
	input  logic [15:0] a,
	input  logic        cpu_wr,
	input  logic        cpu_rd,
	output reg_sel_t    sel,
	output logic        wr_en,
	output logic        rd_en
);

	logic ffxx;
	logic ff1x;
	logic ff2x;
	logic ff3x;
	logic in_range;
	logic [15:0] offset;

	// page and row terms, as in the gate netlist.
	assign ffxx = (a[15:8] == 8'hFF);
	assign ff1x = ffxx && (a[7:4] == 4'h1);
	assign ff2x = ffxx && (a[7:4] == 4'h2);
	assign ff3x = ffxx && (a[7:4] == 4'h3);

	// sound window first, then trim to ff10..ff26.
	assign offset = a - REG_ADDR_BASE;
	assign in_range = (ff1x || ff2x || ff3x) && (offset < 16'(NUM_REGS));

	always_comb begin
		sel = R_NONE;
		if (ff1x) begin
			case (a[3:0])
				4'h0: sel = R_NR10;
				4'h1: sel = R_NR11;
				4'h2: sel = R_NR12;
				4'h3: sel = R_NR13;
				4'h4: sel = R_NR14;
				4'h6: sel = R_NR21;
				4'h7: sel = R_NR22;
				4'h8: sel = R_NR23;
				4'h9: sel = R_NR24;
				4'hA: sel = R_NR30;
				4'hB: sel = R_NR31;
				4'hC: sel = R_NR32;
				4'hD: sel = R_NR33;
				4'hE: sel = R_NR34;
				default: sel = R_NONE;   // ff15, ff1f.
			endcase
		end else if (ff2x) begin
			case (a[3:0])
				4'h0: sel = R_NR41;
				4'h1: sel = R_NR42;
				4'h2: sel = R_NR43;
				4'h3: sel = R_NR44;
				4'h4: sel = R_NR50;
				4'h5: sel = R_NR51;
				4'h6: sel = R_NR52;
				default: sel = R_NONE;
			endcase
		end
	end

	assign wr_en = cpu_wr && (sel != R_NONE);
	assign rd_en = cpu_rd && in_range;   // holes still answer reads.

endmodule

`default_nettype wire

//--- apu_frame_seq.sv
`timescale 1ns/1ns
`default_nettype none

module apu_frame_seq import apu_sound_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic power,
	output logic len_tick,
	output logic env_tick
);

	logic [DIV_W-1:0] div_cnt;
	seq_step_t step;
	logic step_end;

	assign step_end = (div_cnt == DIV_LAST);

	always_ff @(posedge clk) begin
		if (reset || !power) begin
			div_cnt <= '0;
			step <= STEP0;
		end else if (step_end) begin
			div_cnt <= '0;
			step <= seq_step_t'(step + 3'd1);
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// one pulse per finished step.
	always_ff @(posedge clk) begin
		if (reset || !power) begin
			len_tick <= 1'b0;
			env_tick <= 1'b0;
		end else begin
			len_tick <= step_end && !step[0];       // steps 0, 2, 4, 6.
			env_tick <= step_end && (step == STEP7);
		end
	end

endmodule

`default_nettype wire

//--- apu_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module apu_mixer import apu_sound_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic [VOL_W-1:0] ch1_level,
	input  logic [VOL_W-1:0] ch2_level,
	input  logic [7:0]       nr50,
	input  logic [7:0]       nr51,
	output logic [OUT_W-1:0] left,
	output logic [OUT_W-1:0] right
);

	logic [VOL_W:0] left_sum;
	logic [VOL_W:0] right_sum;
	logic [3:0] left_gain;
	logic [3:0] right_gain;

	// nr51: bits 4-5 left, bits 0-1 right.
	assign left_sum = (nr51[4] ? {1'b0, ch1_level} : '0)
		+ (nr51[5] ? {1'b0, ch2_level} : '0);
	assign right_sum = (nr51[0] ? {1'b0, ch1_level} : '0)
		+ (nr51[1] ? {1'b0, ch2_level} : '0);

	assign left_gain = {1'b0, nr50[6:4]} + 4'd1;   // 1..8.
	assign right_gain = {1'b0, nr50[2:0]} + 4'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			left <= '0;
			right <= '0;
		end else begin
			left <= OUT_W'(left_sum) * OUT_W'(left_gain);
			right <= OUT_W'(right_sum) * OUT_W'(right_gain);
		end
	end

endmodule

`default_nettype wire

//--- apu_reg_pkg.sv
`default_nettype none

package apu_reg_pkg;

	// one entry per stored sound register.
	typedef enum logic [4:0] {
		R_NR10, R_NR11, R_NR12, R_NR13, R_NR14,
		R_NR21, R_NR22, R_NR23, R_NR24,
		R_NR30, R_NR31, R_NR32, R_NR33, R_NR34,
		R_NR41, R_NR42, R_NR43, R_NR44,
		R_NR50, R_NR51, R_NR52,
		R_NONE
	} reg_sel_t;

	localparam logic [15:0] REG_ADDR_BASE = 16'hFF10;
	localparam int NUM_REGS = 23;   // ff10..ff26, holes included.
	localparam int NUM_SEL = 21;
	localparam logic [7:0] REG_RESET = 8'h00;

	// bits that read back as one, by address slot.
	localparam logic [7:0] READ_MASK [NUM_REGS] = '{
		8'h80, 8'h3F, 8'h00, 8'hFF, 8'hBF,   // nr10..nr14.
		8'hFF,                               // ff15 hole.
		8'h3F, 8'h00, 8'hFF, 8'hBF,          // nr21..nr24.
		8'h7F, 8'hFF, 8'h9F, 8'hFF, 8'hBF,   // nr30..nr34.
		8'hFF,                               // ff1f hole.
		8'hFF, 8'h00, 8'h00, 8'hBF,          // nr41..nr44.
		8'h00, 8'h00, 8'h70                  // nr50..nr52.
	};

	// address slot of each register select.
	localparam logic [4:0] REG_SLOT [NUM_SEL] = '{
		5'd0, 5'd1, 5'd2, 5'd3, 5'd4,
		5'd6, 5'd7, 5'd8, 5'd9,
		5'd10, 5'd11, 5'd12, 5'd13, 5'd14,
		5'd16, 5'd17, 5'd18, 5'd19,
		5'd20, 5'd21, 5'd22
	};

endpackage

`default_nettype wire

//--- apu_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apu_regs import apu_reg_pkg::*, apu_sound_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  reg_sel_t             sel,
	input  logic                 wr_en,
	input  logic                 rd_en,
	input  logic [7:0]           wdata,
	input  logic                 ch1_active,
	input  logic                 ch2_active,
	output logic [7:0]           rdata,
	output logic                 power,
	output logic [1:0]           ch1_duty,
	output logic [LEN_W-1:0]     ch1_length_load,
	output logic [VOL_W-1:0]     ch1_env_init,
	output logic                 ch1_env_dir,
	output logic [ENV_PER_W-1:0] ch1_env_period,
	output logic [FREQ_W-1:0]    ch1_freq,
	output logic                 ch1_length_en,
	output logic                 ch1_trigger,
	output logic [1:0]           ch2_duty,
	output logic [LEN_W-1:0]     ch2_length_load,
	output logic [VOL_W-1:0]     ch2_env_init,
	output logic                 ch2_env_dir,
	output logic [ENV_PER_W-1:0] ch2_env_period,
	output logic [FREQ_W-1:0]    ch2_freq,
	output logic                 ch2_length_en,
	output logic                 ch2_trigger,
	output logic [7:0]           nr50,
	output logic [7:0]           nr51
);

	logic [7:0] regs [NUM_SEL];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_SEL; i++)
				regs[i] <= REG_RESET;
		end else if (wr_en && sel == R_NR52) begin
			if (!wdata[7]) begin
				// power off wipes the whole file.
				for (int i = 0; i < NUM_SEL; i++)
					regs[i] <= REG_RESET;
			end else begin
				regs[R_NR52] <= 8'h80;
			end
		end else if (wr_en && power) begin
			regs[sel] <= wdata;
		end
	end

	assign power = regs[R_NR52][7];

	// bit 7 of nrx4 starts the channel.
	always_ff @(posedge clk) begin
		if (reset) begin
			ch1_trigger <= 1'b0;
			ch2_trigger <= 1'b0;
		end else begin
			ch1_trigger <= wr_en && power && (sel == R_NR14) && wdata[7];
			ch2_trigger <= wr_en && power && (sel == R_NR24) && wdata[7];
		end
	end

	always_comb begin
		rdata = 8'h00;
		if (rd_en) begin
			if (sel == R_NONE)
				rdata = 8'hFF;   // hole.
			else if (sel == R_NR52)
				rdata = {power, 5'b0, ch2_active, ch1_active} | READ_MASK[REG_SLOT[sel]];
			else
				rdata = regs[sel] | READ_MASK[REG_SLOT[sel]];
		end
	end

	assign ch1_duty        = regs[R_NR11][7:6];
	assign ch1_length_load = regs[R_NR11][5:0];
	assign ch1_env_init    = regs[R_NR12][7:4];
	assign ch1_env_dir     = regs[R_NR12][3];
	assign ch1_env_period  = regs[R_NR12][2:0];
	assign ch1_freq        = {regs[R_NR14][2:0], regs[R_NR13]};
	assign ch1_length_en   = regs[R_NR14][6];

	assign ch2_duty        = regs[R_NR21][7:6];
	assign ch2_length_load = regs[R_NR21][5:0];
	assign ch2_env_init    = regs[R_NR22][7:4];
	assign ch2_env_dir     = regs[R_NR22][3];
	assign ch2_env_period  = regs[R_NR22][2:0];
	assign ch2_freq        = {regs[R_NR24][2:0], regs[R_NR23]};
	assign ch2_length_en   = regs[R_NR24][6];

	assign nr50 = regs[R_NR50];
	assign nr51 = regs[R_NR51];

endmodule

`default_nettype wire

//--- apu_sound_pkg.sv
`default_nettype none

package apu_sound_pkg;

	// 4.194304 MHz / 8192 = 512 Hz.
	localparam int FRAME_DIV = 8192;
	localparam int DIV_W = $clog2(FRAME_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(FRAME_DIV - 1);

	localparam int VOL_W = 4;
	localparam int OUT_W = 8;
	localparam int FREQ_W = 11;
	localparam int LEN_W = 6;
	localparam int ENV_PER_W = 3;

	// 12.5, 25, 50 and 75 percent.
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b0000_0001,
		8'b1000_0001,
		8'b1000_0111,
		8'b0111_1110
	};

	typedef enum logic [2:0] {
		STEP0,
		STEP1,
		STEP2,
		STEP3,
		STEP4,
		STEP5,
		STEP6,
		STEP7
	} seq_step_t;

endpackage

`default_nettype wire

//--- apu_square.sv
`timescale 1ns/1ns
`default_nettype none

module apu_square import apu_sound_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 power,
	input  logic                 trigger,
	input  logic [1:0]           duty,
	input  logic [LEN_W-1:0]     length_load,
	input  logic                 length_en,
	input  logic [VOL_W-1:0]     env_init,
	input  logic                 env_dir,
	input  logic [ENV_PER_W-1:0] env_period,
	input  logic [FREQ_W-1:0]    freq,
	input  logic                 len_tick,
	input  logic                 env_tick,
	output logic                 active,
	output logic [VOL_W-1:0]     level
);

	logic [FREQ_W+1:0] timer;
	logic [FREQ_W+1:0] timer_load;
	logic [2:0] duty_pos;
	logic [LEN_W:0] len_cnt;
	logic [ENV_PER_W-1:0] env_cnt;
	logic [VOL_W-1:0] volume;

	// (2048 - freq) * 4 - 1.
	assign timer_load = {~freq, 2'b11};

	always_ff @(posedge clk) begin
		if (reset || !power) begin
			timer <= '0;
			duty_pos <= 3'd0;
		end else if (trigger) begin
			timer <= timer_load;
		end else if (timer == '0) begin
			timer <= timer_load;
			duty_pos <= duty_pos + 3'd1;
		end else begin
			timer <= timer - 1'b1;
		end
	end

	// length counter owns the active flag.
	always_ff @(posedge clk) begin
		if (reset || !power) begin
			len_cnt <= '0;
			active <= 1'b0;
		end else if (trigger) begin
			len_cnt <= (LEN_W+1)'(64) - {1'b0, length_load};
			active <= 1'b1;
		end else if (len_tick && length_en && len_cnt != '0) begin
			len_cnt <= len_cnt - 1'b1;
			if (len_cnt == (LEN_W+1)'(1))
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !power) begin
			env_cnt <= '0;
			volume <= '0;
		end else if (trigger) begin
			env_cnt <= env_period;
			volume <= env_init;
		end else if (env_tick && env_period != '0) begin
			if (env_cnt > ENV_PER_W'(1)) begin
				env_cnt <= env_cnt - 1'b1;
			end else begin
				env_cnt <= env_period;
				if (env_dir && volume != '1)
					volume <= volume + 1'b1;
				else if (!env_dir && volume != '0)
					volume <= volume - 1'b1;
			end
		end
	end

	assign level = (active && DUTY_TABLE[duty][duty_pos]) ? volume : '0;

endmodule

`default_nettype wire

//--- apu_top.sv
`timescale 1ns/1ns
`default_nettype none

module apu_top import apu_reg_pkg::*, apu_sound_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic [15:0]      a,
	input  logic [7:0]       wdata,
	input  logic             cpu_wr,
	input  logic             cpu_rd,
	output logic [7:0]       rdata,
	output logic [OUT_W-1:0] left,
	output logic [OUT_W-1:0] right
);

	reg_sel_t sel;
	logic wr_en;
	logic rd_en;
	logic power;
	logic len_tick;
	logic env_tick;
	logic [7:0] nr50;
	logic [7:0] nr51;

	logic [1:0] ch1_duty, ch2_duty;
	logic [LEN_W-1:0] ch1_length_load, ch2_length_load;
	logic [VOL_W-1:0] ch1_env_init, ch2_env_init;
	logic ch1_env_dir, ch2_env_dir;
	logic [ENV_PER_W-1:0] ch1_env_period, ch2_env_period;
	logic [FREQ_W-1:0] ch1_freq, ch2_freq;
	logic ch1_length_en, ch2_length_en;
	logic ch1_trigger, ch2_trigger;
	logic ch1_active, ch2_active;
	logic [VOL_W-1:0] ch1_level, ch2_level;

	apu_decode u_decode (
		.a(a), .cpu_wr(cpu_wr), .cpu_rd(cpu_rd),
		.sel(sel), .wr_en(wr_en), .rd_en(rd_en)
	);

	apu_regs u_regs (
		.clk(clk), .reset(reset), .sel(sel), .wr_en(wr_en), .rd_en(rd_en),
		.wdata(wdata), .ch1_active(ch1_active), .ch2_active(ch2_active),
		.rdata(rdata), .power(power),
		.ch1_duty(ch1_duty), .ch1_length_load(ch1_length_load),
		.ch1_env_init(ch1_env_init), .ch1_env_dir(ch1_env_dir),
		.ch1_env_period(ch1_env_period), .ch1_freq(ch1_freq),
		.ch1_length_en(ch1_length_en), .ch1_trigger(ch1_trigger),
		.ch2_duty(ch2_duty), .ch2_length_load(ch2_length_load),
		.ch2_env_init(ch2_env_init), .ch2_env_dir(ch2_env_dir),
		.ch2_env_period(ch2_env_period), .ch2_freq(ch2_freq),
		.ch2_length_en(ch2_length_en), .ch2_trigger(ch2_trigger),
		.nr50(nr50), .nr51(nr51)
	);

	apu_frame_seq u_frame_seq (
		.clk(clk), .reset(reset), .power(power),
		.len_tick(len_tick), .env_tick(env_tick)
	);

	apu_square u_ch1 (
		.clk(clk), .reset(reset), .power(power), .trigger(ch1_trigger),
		.duty(ch1_duty), .length_load(ch1_length_load), .length_en(ch1_length_en),
		.env_init(ch1_env_init), .env_dir(ch1_env_dir), .env_period(ch1_env_period),
		.freq(ch1_freq), .len_tick(len_tick), .env_tick(env_tick),
		.active(ch1_active), .level(ch1_level)
	);

	apu_square u_ch2 (
		.clk(clk), .reset(reset), .power(power), .trigger(ch2_trigger),
		.duty(ch2_duty), .length_load(ch2_length_load), .length_en(ch2_length_en),
		.env_init(ch2_env_init), .env_dir(ch2_env_dir), .env_period(ch2_env_period),
		.freq(ch2_freq), .len_tick(len_tick), .env_tick(env_tick),
		.active(ch2_active), .level(ch2_level)
	);

	apu_mixer u_mixer (
		.clk(clk), .reset(reset), .ch1_level(ch1_level), .ch2_level(ch2_level),
		.nr50(nr50), .nr51(nr51), .left(left), .right(right)
	);

endmodule

`default_nettype wire

//--- compile.f
apu_reg_pkg.sv
apu_sound_pkg.sv
apu_decode.sv
apu_regs.sv
apu_frame_seq.sv
apu_square.sv
apu_mixer.sv
apu_top.sv
tb_apu_top.sv

//--- tb_apu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_apu_top import apu_sound_pkg::*; ();

	localparam int NUM_ROWS = 26;
	localparam longint WATCHDOG_CYCLES = NUM_ROWS * 10 + 40 * FRAME_DIV;

	logic clk;
	logic reset;
	logic [15:0] a;
	logic [7:0] wdata;
	logic cpu_wr;
	logic cpu_rd;
	logic [7:0] rdata;
	logic [OUT_W-1:0] left;
	logic [OUT_W-1:0] right;

	// stimulus table: address, write data, read mask, inside ff10..ff26.
	logic [15:0] row_addr [NUM_ROWS];
	logic [7:0] row_data [NUM_ROWS];
	logic [7:0] row_mask [NUM_ROWS];
	logic row_dec [NUM_ROWS];
	int row_count = 0;

	int errors = 0;
	int checks = 0;
	longint cycle_count = 0;

	apu_top u_apu_top (
		.clk(clk), .reset(reset), .a(a), .wdata(wdata),
		.cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .rdata(rdata),
		.left(left), .right(right)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	task automatic add_row(input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] mask, input logic rnd, input logic dec);
		logic [31:0] r;
		r = $urandom;
		row_addr[row_count] = addr;
		row_data[row_count] = rnd ? r[7:0] : data;
		row_mask[row_count] = mask;
		row_dec[row_count] = dec;
		row_count++;
	endtask

	// mask bits read as one; outside the window nothing answers.
	function automatic logic [7:0] expected_read(input logic [7:0] data,
		input logic [7:0] mask, input logic dec);
		return dec ? (data | mask) : 8'h00;
	endfunction

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		a <= addr;
		wdata <= data;
		cpu_wr <= 1'b1;
		cpu_rd <= 1'b0;
		@(posedge clk);   // write lands here.
		cpu_wr <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] value);
		@(posedge clk);
		a <= addr;
		cpu_rd <= 1'b1;
		cpu_wr <= 1'b0;
		@(negedge clk);
		value = rdata;
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s expected %02h got %02h", $time, name, exp, got);
		end
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		bus_read(addr, got);
		check_byte($sformatf("rdata[%04h]", addr), exp, got);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [7:0] got;
		logic [7:0] peak;
		longint start;
		reset = 1'b1;
		a = 16'h0000;
		wdata = 8'h00;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		void'($urandom(32'h11e5cc14));

		add_row(16'hFF10, 8'h00, 8'h80, 1'b1, 1'b1);
		add_row(16'hFF11, 8'h00, 8'h3F, 1'b1, 1'b1);
		add_row(16'hFF12, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF13, 8'h00, 8'hFF, 1'b1, 1'b1);
		add_row(16'hFF14, 8'h40, 8'hBF, 1'b0, 1'b1);   // no trigger.
		add_row(16'hFF15, 8'h5A, 8'hFF, 1'b0, 1'b1);
		add_row(16'hFF16, 8'h00, 8'h3F, 1'b1, 1'b1);
		add_row(16'hFF17, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF18, 8'h00, 8'hFF, 1'b1, 1'b1);
		add_row(16'hFF19, 8'h45, 8'hBF, 1'b0, 1'b1);
		add_row(16'hFF1A, 8'h00, 8'h7F, 1'b1, 1'b1);
		add_row(16'hFF1B, 8'h00, 8'hFF, 1'b1, 1'b1);
		add_row(16'hFF1C, 8'h00, 8'h9F, 1'b1, 1'b1);
		add_row(16'hFF1D, 8'h00, 8'hFF, 1'b1, 1'b1);
		add_row(16'hFF1E, 8'h40, 8'hBF, 1'b0, 1'b1);
		add_row(16'hFF1F, 8'hA5, 8'hFF, 1'b0, 1'b1);
		add_row(16'hFF20, 8'h00, 8'hFF, 1'b1, 1'b1);
		add_row(16'hFF21, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF22, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF23, 8'h40, 8'hBF, 1'b0, 1'b1);
		add_row(16'hFF24, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF25, 8'h00, 8'h00, 1'b1, 1'b1);
		add_row(16'hFF0F, 8'h33, 8'h00, 1'b0, 1'b0);
		add_row(16'hFF27, 8'h33, 8'h00, 1'b0, 1'b0);
		add_row(16'hFF30, 8'h33, 8'h00, 1'b0, 1'b0);
		add_row(16'h0010, 8'h33, 8'h00, 1'b0, 1'b0);

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_byte("left", 8'h00, left);
		check_byte("right", 8'h00, right);
		read_check(16'hFF26, 8'h70);

		// readback with power on.
		bus_write(16'hFF26, 8'h80);
		for (int i = 0; i < NUM_ROWS; i++) begin
			bus_write(row_addr[i], row_data[i]);
			read_check(row_addr[i], expected_read(row_data[i], row_mask[i], row_dec[i]));
		end

		// power off wipes the file and locks writes.
		bus_write(16'hFF26, 8'h00);
		for (int i = 0; i < NUM_ROWS; i++)
			read_check(row_addr[i], expected_read(8'h00, row_mask[i], row_dec[i]));
		bus_write(16'hFF11, 8'hC0);
		read_check(16'hFF11, 8'h3F);
		read_check(16'hFF26, 8'h70);
		bus_write(16'hFF26, 8'h80);
		for (int i = 0; i < NUM_ROWS; i++)
			read_check(row_addr[i], expected_read(8'h00, row_mask[i], row_dec[i]));
		read_check(16'hFF26, 8'hF0);

		bus_write(16'hFF12, 8'hF0);
		bus_write(16'hFF11, 8'h80);
		bus_write(16'hFF14, 8'h80);
		repeat (2) @(posedge clk);   // trigger, then active.
		read_check(16'hFF26, 8'hF1);
		bus_write(16'hFF17, 8'hF0);
		bus_write(16'hFF16, 8'h80);
		bus_write(16'hFF19, 8'h80);
		repeat (2) @(posedge clk);
		read_check(16'hFF26, 8'hF3);

		// channel 2 with two length steps left.
		bus_write(16'hFF16, 8'hBE);
		bus_write(16'hFF19, 8'hC0);
		start = cycle_count;
		repeat (2) @(posedge clk);
		read_check(16'hFF26, 8'hF3);
		got = 8'hFF;
		while (got[1] && cycle_count - start < 5 * FRAME_DIV * 2)
			bus_read(16'hFF26, got);
		checks++;
		assert (!got[1]) else begin
			errors++;
			$display("channel 2 length counter did not expire within %0d cycles",
				5 * FRAME_DIV * 2);
		end
		checks++;
		assert (cycle_count - start >= FRAME_DIV) else begin
			errors++;
			$display("channel 2 expired after only %0d cycles", cycle_count - start);
		end

		// ch1 left only, gain 4, volume 5, 32 clocks per duty step.
		bus_write(16'hFF25, 8'h10);
		bus_write(16'hFF24, 8'h30);
		bus_write(16'hFF12, 8'h50);
		bus_write(16'hFF11, 8'h80);
		bus_write(16'hFF13, 8'hF8);
		bus_write(16'hFF14, 8'h87);
		repeat (4) @(posedge clk);
		peak = 8'h00;
		repeat (4 * 256) begin
			@(negedge clk);
			if (left > peak)
				peak = left;
			if (left != 8'd0 && left != 8'd20)
				check_byte("left", 8'd20, left);
			check_byte("right", 8'h00, right);
		end
		check_byte("left peak", 8'd20, peak);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
